// File: logic/uart_pkg.sv
package uart_pkg;

    // bus and frame geometry
    localparam int WORD_W    = 32;
    localparam int DATA_W    = 8;                 // data bits per frame
    localparam int FRAME_W   = 11;                // start + 8 data + parity + stop
    localparam int BYTES_W   = WORD_W / DATA_W;   // frames per bus word

    // address map, per channel
    localparam int CH_STRIDE  = 16;               // bytes between channel blocks
    localparam int OFS_TXDATA = 0;                // write only
    localparam int OFS_STATUS = 4;                // read only

    // ahb transfer type
    typedef enum logic [1:0] {
        HTRANS_IDLE   = 2'b00,
        HTRANS_BUSY   = 2'b01,
        HTRANS_NONSEQ = 2'b10,
        HTRANS_SEQ    = 2'b11
    } htrans_e;

    // ahb response, upper bit of the port is always zero
    typedef enum logic {
        HRESP_OKAY  = 1'b0,
        HRESP_ERROR = 1'b1
    } hresp_e;

    // channel serializer
    typedef enum logic [1:0] {
        SER_IDLE = 2'b00,
        SER_LOAD = 2'b01,
        SER_SEND = 2'b10
    } ser_state_e;

endpackage

// File: logic/tx_word_fifo.sv
module tx_word_fifo
    import uart_pkg::*;
#(
    parameter int FIFO_DEPTH = 4
) (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                push,
    input  logic [WORD_W-1:0]   push_data,
    input  logic                pop,
    output logic [WORD_W-1:0]   pop_data,
    output logic                empty,
    output logic                full
);

    localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

    logic [WORD_W-1:0]  mem [FIFO_DEPTH];
    logic [PTR_W-1:0]   wr_ptr;
    logic [PTR_W-1:0]   rd_ptr;
    logic [CNT_W-1:0]   count;
    logic [CNT_W-1:0]   count_next;
    logic               push_ok;
    logic               pop_ok;

    assign push_ok    = push && (count != CNT_W'(FIFO_DEPTH));
    assign pop_ok     = pop && (count != '0);
    assign count_next = count + CNT_W'(push_ok) - CNT_W'(pop_ok);

    assign empty = (count == '0);
    // looks one cycle ahead, so a write seen now lands on this value
    assign full  = (count_next == CNT_W'(FIFO_DEPTH));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push_ok) begin
                wr_ptr <= (wr_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop_ok) begin
                rd_ptr <= (rd_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            count <= count_next;
        end
    end

    always_ff @(posedge clk) begin
        if (push_ok) begin
            mem[wr_ptr] <= push_data;
        end
        if (pop_ok) begin
            pop_data <= mem[rd_ptr];   // valid the cycle after pop
        end
    end

endmodule

// File: logic/uart_tx_channel.sv
module uart_tx_channel
    import uart_pkg::*;
#(
    parameter int FIFO_DEPTH = 4,
    parameter int BAUD_DIV   = 8
) (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                wr_en,
    input  logic [WORD_W-1:0]   wr_data,
    output logic                tx,
    output logic                fifo_full,
    output logic                busy,
    output logic                word_done
);

    localparam int BAUD_W  = (BAUD_DIV > 1) ? $clog2(BAUD_DIV) : 1;
    localparam int BIT_W   = $clog2(FRAME_W);
    localparam int BYTE_CW = (BYTES_W > 1) ? $clog2(BYTES_W) : 1;
    localparam int SHIFT_W = BYTES_W * FRAME_W;

    ser_state_e             state;
    logic                   fifo_empty;
    logic                   fifo_pop;
    logic [WORD_W-1:0]      fifo_data;

    logic [SHIFT_W-1:0]     frame_d;
    logic [SHIFT_W-1:0]     shift_q;
    logic [BAUD_W-1:0]      baud_cnt;
    logic [BIT_W-1:0]       bit_cnt;
    logic [BYTE_CW-1:0]     byte_cnt;
    logic                   bit_end;
    logic                   frame_end;
    logic                   word_end;

    tx_word_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) u_fifo (
        .clk       (clk),
        .rst_n     (rst_n),
        .push      (wr_en),
        .push_data (wr_data),
        .pop       (fifo_pop),
        .pop_data  (fifo_data),
        .empty     (fifo_empty),
        .full      (fifo_full)
    );

    assign fifo_pop = (state == SER_IDLE) && !fifo_empty;

    // four frames, {stop, parity, data, start} each, byte 0 in the low bits
    always_comb begin : build_frames
        logic [DATA_W-1:0] byte_v;
        frame_d = '0;
        for (int i = 0; i < BYTES_W; i++) begin
            byte_v = fifo_data[i*DATA_W +: DATA_W];
            frame_d[i*FRAME_W +: FRAME_W] = {1'b1, ^byte_v, byte_v, 1'b0};
        end
    end

    assign bit_end   = (state == SER_SEND) && (baud_cnt == BAUD_W'(BAUD_DIV - 1));
    assign frame_end = bit_end && (bit_cnt == BIT_W'(FRAME_W - 1));
    assign word_end  = frame_end && (byte_cnt == BYTE_CW'(BYTES_W - 1));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= SER_IDLE;
        end else begin
            case (state)
                SER_IDLE: if (!fifo_empty) state <= SER_LOAD;
                SER_LOAD: state <= SER_SEND;     // fifo data valid here
                SER_SEND: if (word_end) state <= SER_IDLE;
                default:  state <= SER_IDLE;
            endcase
        end
    end

    // baud, bit and byte counters
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            baud_cnt <= '0;
            bit_cnt  <= '0;
            byte_cnt <= '0;
        end else if (state == SER_LOAD) begin
            baud_cnt <= '0;
            bit_cnt  <= '0;
            byte_cnt <= '0;
        end else if (state == SER_SEND) begin
            baud_cnt <= bit_end ? '0 : baud_cnt + 1'b1;
            if (bit_end) begin
                bit_cnt <= frame_end ? '0 : bit_cnt + 1'b1;
            end
            if (frame_end) begin
                byte_cnt <= word_end ? '0 : byte_cnt + 1'b1;
            end
        end
    end

    // frames leave lsb first
    always_ff @(posedge clk) begin
        if (state == SER_LOAD) begin
            shift_q <= frame_d;
        end else if (bit_end) begin
            shift_q <= {1'b1, shift_q[SHIFT_W-1:1]};
        end
    end

    assign tx        = (state == SER_SEND) ? shift_q[0] : 1'b1;   // idle line is high
    assign busy      = (state != SER_IDLE) || !fifo_empty;
    assign word_done = word_end;   // last cycle of the last stop bit

endmodule

// File: logic/ahb_uart_regs.sv
module ahb_uart_regs
    import uart_pkg::*;
#(
    parameter int NUM_CH = 2
) (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                hsel,
    input  logic [WORD_W-1:0]   haddr,
    input  logic                hwrite,
    input  logic [2:0]          hsize,      // word access assumed
    input  logic [2:0]          hburst,     // bursts not decoded
    input  logic [1:0]          htrans,
    input  logic                hmastlock,  // no locked sequences
    input  logic [WORD_W-1:0]   hwdata,
    input  logic [NUM_CH-1:0]   fifo_full,
    input  logic [NUM_CH-1:0]   busy,
    input  logic [NUM_CH-1:0]   done_pending,
    output logic [WORD_W-1:0]   hrdata,
    output logic                hready,
    output logic [1:0]          hresp,
    output logic [NUM_CH-1:0]   wr_en,
    output logic [WORD_W-1:0]   wr_data,
    output logic                err_pulse
);

    localparam int OFS_W = $clog2(CH_STRIDE);
    localparam int CH_W  = (NUM_CH > 1) ? $clog2(NUM_CH) : 1;

    logic [WORD_W-1:0]  ch_idx;
    logic [OFS_W-1:0]   ofs;
    logic [CH_W-1:0]    ch_sel;
    logic               xfer;
    logic               sel_txdata;
    logic               sel_status;

    // registered address phase
    logic               ap_valid;
    logic               ap_write;
    logic               ap_txdata;
    logic               ap_status;
    logic               ap_full;
    logic [CH_W-1:0]    ap_ch;

    logic               wr_ok;
    hresp_e             resp;

    // channel index is haddr / CH_STRIDE, stride is a power of two
    assign ch_idx     = haddr >> OFS_W;
    assign ofs        = haddr[OFS_W-1:0];
    assign ch_sel     = ch_idx[CH_W-1:0];
    assign sel_txdata = (ofs == OFS_W'(OFS_TXDATA));
    assign sel_status = (ofs == OFS_W'(OFS_STATUS));

    // only nonseq transfers to an existing channel count
    assign xfer = hsel && (htrans_e'(htrans) == HTRANS_NONSEQ)
                  && (ch_idx < WORD_W'(NUM_CH));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ap_valid  <= 1'b0;
            ap_write  <= 1'b0;
            ap_txdata <= 1'b0;
            ap_status <= 1'b0;
            ap_full   <= 1'b0;
            hready    <= 1'b0;   // held low until reset is gone
        end else begin
            ap_valid  <= xfer;
            ap_write  <= hwrite;
            ap_txdata <= sel_txdata;
            ap_status <= sel_status;
            ap_full   <= fifo_full[ch_sel];   // fifo state seen in the address phase
            hready    <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (xfer) begin
            ap_ch <= ch_sel;
        end
    end

    // data phase
    assign wr_ok = ap_valid && ap_write && ap_txdata && !ap_full;

    // txdata is write only, and a full fifo drops the word
    assign resp = (ap_valid && ap_txdata && (!ap_write || ap_full)) ? HRESP_ERROR
                                                                    : HRESP_OKAY;

    assign hresp     = {1'b0, resp};
    assign err_pulse = (resp == HRESP_ERROR);
    assign wr_data   = hwdata;   // write data arrives in the data phase

    always_comb begin
        wr_en = '0;
        if (wr_ok) begin
            wr_en[ap_ch] = 1'b1;
        end
    end

    // status word, everything else reads as zero
    always_comb begin
        hrdata = '0;
        if (ap_valid && !ap_write && ap_status) begin
            hrdata[0] = fifo_full[ap_ch];
            hrdata[1] = busy[ap_ch];
            hrdata[2] = done_pending[ap_ch];
        end
    end

endmodule

// File: logic/uart_irq_ctrl.sv
module uart_irq_ctrl #(
    parameter int NUM_CH = 2
) (
    input  logic                clk,
    input  logic                rst_n,
    input  logic [NUM_CH-1:0]   word_done,
    input  logic                err_pulse,
    input  logic                int_clear,
    output logic [NUM_CH-1:0]   done_pending,
    output logic                irq
);

    logic [NUM_CH-1:0]  done_q;
    logic               err_q;

    // sticky flags, clear wins over a new event
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            done_q <= '0;
            err_q  <= 1'b0;
        end else if (int_clear) begin
            done_q <= '0;
            err_q  <= 1'b0;
        end else begin
            done_q <= done_q | word_done;
            err_q  <= err_q | err_pulse;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            irq <= 1'b0;
        end else begin
            irq <= (|done_q) || err_q;   // one cycle behind the flags
        end
    end

    assign done_pending = done_q;

endmodule

// File: logic/uart_tx_top.sv
module uart_tx_top
    import uart_pkg::*;
#(
    parameter int NUM_CH     = 2,
    parameter int FIFO_DEPTH = 4,
    parameter int BAUD_DIV   = 8     // 434 gives 115200 baud at 50 MHz
) (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                hsel,
    input  logic [WORD_W-1:0]   haddr,
    input  logic                hwrite,
    input  logic [2:0]          hsize,
    input  logic [2:0]          hburst,
    input  logic [1:0]          htrans,
    input  logic                hmastlock,
    input  logic [WORD_W-1:0]   hwdata,
    output logic [WORD_W-1:0]   hrdata,
    output logic                hready,
    output logic [1:0]          hresp,
    input  logic                int_clear,
    output logic [NUM_CH-1:0]   tx,
    output logic                irq
);

    logic [NUM_CH-1:0]  wr_en;
    logic [WORD_W-1:0]  wr_data;
    logic [NUM_CH-1:0]  fifo_full;
    logic [NUM_CH-1:0]  busy;
    logic [NUM_CH-1:0]  word_done;
    logic [NUM_CH-1:0]  done_pending;
    logic               err_pulse;

    ahb_uart_regs #(
        .NUM_CH (NUM_CH)
    ) u_regs (
        .clk          (clk),
        .rst_n        (rst_n),
        .hsel         (hsel),
        .haddr        (haddr),
        .hwrite       (hwrite),
        .hsize        (hsize),
        .hburst       (hburst),
        .htrans       (htrans),
        .hmastlock    (hmastlock),
        .hwdata       (hwdata),
        .fifo_full    (fifo_full),
        .busy         (busy),
        .done_pending (done_pending),
        .hrdata       (hrdata),
        .hready       (hready),
        .hresp        (hresp),
        .wr_en        (wr_en),
        .wr_data      (wr_data),
        .err_pulse    (err_pulse)
    );

    for (genvar i = 0; i < NUM_CH; i++) begin : gen_ch
        uart_tx_channel #(
            .FIFO_DEPTH (FIFO_DEPTH),
            .BAUD_DIV   (BAUD_DIV)
        ) u_ch (
            .clk       (clk),
            .rst_n     (rst_n),
            .wr_en     (wr_en[i]),
            .wr_data   (wr_data),
            .tx        (tx[i]),
            .fifo_full (fifo_full[i]),
            .busy      (busy[i]),
            .word_done (word_done[i])
        );
    end

    uart_irq_ctrl #(
        .NUM_CH (NUM_CH)
    ) u_irq (
        .clk          (clk),
        .rst_n        (rst_n),
        .word_done    (word_done),
        .err_pulse    (err_pulse),
        .int_clear    (int_clear),
        .done_pending (done_pending),
        .irq          (irq)
    );

endmodule

// File: test/tb_clock_gen.sv
module tb_clock_gen #(
    parameter int PERIOD_NS = 8
) (
    output logic clk
);
    timeunit 1ns;
    timeprecision 100ps;

    initial clk = 1'b0;

    always #(PERIOD_NS / 2.0) clk = ~clk;   // 50 percent duty

endmodule

// File: test/uart_tx_asserts.sv
module uart_tx_asserts
    import uart_pkg::*;
#(
    parameter int NUM_CH = 2
) (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                hsel,
    input  logic [1:0]          htrans,
    input  logic                hready,
    input  logic [1:0]          hresp,
    input  logic [NUM_CH-1:0]   tx,
    input  logic [NUM_CH-1:0]   busy
);
    timeunit 1ns;
    timeprecision 100ps;

    // bus never stalls once out of reset
    hready_high: assert property (@(posedge clk) disable iff (!rst_n)
        $past(rst_n) |-> hready)
        else $error("hready low after reset");

    // an error response needs a transfer in the cycle before
    hresp_caused: assert property (@(posedge clk) disable iff (!rst_n)
        (hresp[0] == HRESP_ERROR) |-> $past(hsel && (htrans == HTRANS_NONSEQ)))
        else $error("hresp error without a causing transfer");

    // idle channel keeps its line high
    tx_idle_high: assert property (@(posedge clk) disable iff (!rst_n)
        &(tx | busy))
        else $error("tx low on an idle channel");

endmodule

bind uart_tx_top uart_tx_asserts #(
    .NUM_CH (NUM_CH)
) u_asserts (
    .clk    (clk),
    .rst_n  (rst_n),
    .hsel   (hsel),
    .htrans (htrans),
    .hready (hready),
    .hresp  (hresp),
    .tx     (tx),
    .busy   (busy)
);

// File: test/uart_tx_checker.sv
module uart_tx_checker
    import uart_pkg::*;
#(
    parameter int NUM_CH     = 2,
    parameter int FIFO_DEPTH = 4,
    parameter int BAUD_DIV   = 8
) (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                hsel,
    input  logic [WORD_W-1:0]   haddr,
    input  logic                hwrite,
    input  logic [1:0]          htrans,
    input  logic [WORD_W-1:0]   hwdata,
    input  logic                int_clear,
    input  logic [WORD_W-1:0]   hrdata,
    input  logic [1:0]          hresp,
    input  logic [NUM_CH-1:0]   tx,
    input  logic                irq,
    output int                  mismatches,
    output int                  others,
    output logic                drained
);
    timeunit 1ns;
    timeprecision 100ps;

    localparam int SEND_CYC    = BYTES_W * FRAME_W * BAUD_DIV;
    localparam int START_LIMIT = 2 * BAUD_DIV + 8;   // gap allowed while a word is owed
    localparam int IDLE_LIMIT  = 100000;

    logic [WORD_W-1:0] exp_q [NUM_CH][$];   // expected words per channel

    // model of fifo occupancy and serializer, 0 idle, 1 load, 2 send
    int                 cnt [NUM_CH];
    int                 st [NUM_CH];
    int                 rem [NUM_CH];
    logic [NUM_CH-1:0]  done_m;
    logic               err_m;
    logic               irq_m;

    // registered address phase of the model
    logic               dp_valid;
    logic               dp_write;
    logic               dp_txdata;
    logic               dp_status;
    logic               dp_drop;
    int                 dp_ch;

    initial begin
        mismatches = 0;
        others     = 0;
    end

    always @(posedge clk) begin : model
        logic [NUM_CH-1:0]  push_v;
        logic [NUM_CH-1:0]  pop_v;
        logic [NUM_CH-1:0]  full_v;
        logic [NUM_CH-1:0]  busy_v;
        logic [NUM_CH-1:0]  wd_v;
        logic               exp_err;
        logic [WORD_W-1:0]  exp_rdata;
        int                 a_ch;
        logic               idle_all;
        if (!rst_n) begin
            for (int c = 0; c < NUM_CH; c++) begin
                cnt[c] = 0;
                st[c]  = 0;
                rem[c] = 0;
                exp_q[c].delete();
            end
            done_m   = '0;
            err_m    = 1'b0;
            irq_m    = 1'b0;
            dp_valid = 1'b0;
            dp_ch    = 0;
            drained  = 1'b1;
        end else begin
            for (int c = 0; c < NUM_CH; c++) begin
                push_v[c] = dp_valid && dp_write && dp_txdata && !dp_drop && (dp_ch == c);
                pop_v[c]  = (st[c] == 0) && (cnt[c] != 0);
                full_v[c] = (cnt[c] + int'(push_v[c]) - int'(pop_v[c])) == FIFO_DEPTH;
                busy_v[c] = (st[c] != 0) || (cnt[c] != 0);
                wd_v[c]   = (st[c] == 2) && (rem[c] == 1);
            end
            exp_err   = dp_valid && dp_txdata && (!dp_write || dp_drop);
            exp_rdata = '0;
            if (dp_valid && !dp_write && dp_status) begin
                exp_rdata[0] = full_v[dp_ch];
                exp_rdata[1] = busy_v[dp_ch];
                exp_rdata[2] = done_m[dp_ch];
            end

            if (hresp !== {1'b0, exp_err}) begin
                $display("MISMATCH @%0t: hresp %b, expected %b", $time, hresp, {1'b0, exp_err});
                mismatches++;
            end
            if (hrdata !== exp_rdata) begin
                $display("MISMATCH @%0t: hrdata %h, expected %h", $time, hrdata, exp_rdata);
                mismatches++;
            end
            if (irq !== irq_m) begin
                $display("MISMATCH @%0t: irq %b, expected %b", $time, irq, irq_m);
                mismatches++;
            end

            // line must idle high outside a word
            for (int c = 0; c < NUM_CH; c++) begin
                if (st[c] != 2 && tx[c] !== 1'b1) begin
                    $display("MISMATCH @%0t: ch%0d tx %b outside a word, expected 1",
                             $time, c, tx[c]);
                    mismatches++;
                end
            end

            for (int c = 0; c < NUM_CH; c++) begin
                if (push_v[c]) exp_q[c].push_back(hwdata);   // data phase carries the word
                cnt[c] = cnt[c] + int'(push_v[c]) - int'(pop_v[c]);
                case (st[c])
                    0: if (pop_v[c]) st[c] = 1;
                    1: begin
                        st[c]  = 2;
                        rem[c] = SEND_CYC;
                    end
                    default: begin
                        if (rem[c] == 1) st[c] = 0;
                        rem[c] = rem[c] - 1;
                    end
                endcase
            end

            irq_m = (|done_m) || err_m;
            if (int_clear) begin   // clear beats a new event
                done_m = '0;
                err_m  = 1'b0;
            end else begin
                done_m = done_m | wd_v;
                err_m  = err_m | exp_err;
            end

            // next address phase
            a_ch      = int'(haddr / CH_STRIDE);
            dp_valid  = hsel && (htrans == HTRANS_NONSEQ) && (haddr / CH_STRIDE < NUM_CH);
            dp_write  = hwrite;
            dp_txdata = (haddr % CH_STRIDE) == OFS_TXDATA;
            dp_status = (haddr % CH_STRIDE) == OFS_STATUS;
            if (dp_valid) begin
                dp_ch   = a_ch;
                dp_drop = full_v[a_ch];
            end

            idle_all = !dp_valid;
            for (int c = 0; c < NUM_CH; c++) begin
                if (st[c] != 0 || cnt[c] != 0 || exp_q[c].size() != 0) idle_all = 1'b0;
            end
            drained = idle_all;
        end
    end

    // serial decoders, one per line
    for (genvar g = 0; g < NUM_CH; g++) begin : gen_dec
        logic [WORD_W-1:0] word_acc = '0;
        int                nbytes   = 0;

        always begin : decode
            logic [FRAME_W-1:0] fr;
            logic [WORD_W-1:0]  dummy;
            int                 waited;
            int                 pend;
            logic               found;
            waited = 0;
            pend   = 0;
            found  = 1'b0;
            while (!found && waited < IDLE_LIMIT) begin
                @(posedge clk);
                waited++;
                if (rst_n && tx[g] === 1'b0) begin
                    found = 1'b1;
                end else if (rst_n && exp_q[g].size() != 0) begin
                    pend++;
                    if (pend > START_LIMIT) begin
                        $display("ERROR: channel %0d never started a queued word, time %0t",
                                 g, $time);
                        others++;
                        dummy  = exp_q[g].pop_front();   // give up on it
                        nbytes = 0;
                        pend   = 0;
                    end
                end else begin
                    pend = 0;
                end
            end
            if (found) begin
                repeat (BAUD_DIV / 2 - 1) @(posedge clk);   // move to mid bit
                fr[0] = tx[g];
                for (int b = 1; b < FRAME_W; b++) begin
                    repeat (BAUD_DIV) @(posedge clk);
                    fr[b] = tx[g];
                end
                if (fr[0] !== 1'b0 || fr[FRAME_W-1] !== 1'b1) begin
                    $display("MISMATCH @%0t: ch%0d frame %b has bad start or stop bit",
                             $time, g, fr);
                    mismatches++;
                end
                if (fr[9] !== ^fr[8:1]) begin
                    $display("MISMATCH @%0t: ch%0d parity %b for data %h", $time, g,
                             fr[9], fr[8:1]);
                    mismatches++;
                end
                word_acc[nbytes*DATA_W +: DATA_W] = fr[8:1];
                nbytes++;
                if (nbytes == BYTES_W) begin
                    nbytes = 0;
                    if (exp_q[g].size() == 0) begin
                        $display("MISMATCH @%0t: ch%0d sent %h with no word pending",
                                 $time, g, word_acc);
                        mismatches++;
                    end else begin
                        dummy = exp_q[g].pop_front();
                        if (word_acc !== dummy) begin
                            $display("MISMATCH @%0t: ch%0d sent %h, expected %h",
                                     $time, g, word_acc, dummy);
                            mismatches++;
                        end
                    end
                end
            end
        end
    end

endmodule

// File: test/uart_tx_tb.sv
module uart_tx_tb
    import uart_pkg::*;
();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int NUM_CH      = 2;
    localparam int FIFO_DEPTH  = 4;
    localparam int BAUD_DIV    = 8;
    localparam int DRAIN_LIMIT = 40000;

    logic                clk;
    logic                rst_n;
    logic                hsel;
    logic [WORD_W-1:0]   haddr;
    logic                hwrite;
    logic [2:0]          hsize;
    logic [2:0]          hburst;
    logic [1:0]          htrans;
    logic                hmastlock;
    logic [WORD_W-1:0]   hwdata;
    logic [WORD_W-1:0]   hrdata;
    logic                hready;
    logic [1:0]          hresp;
    logic                int_clear;
    logic [NUM_CH-1:0]   tx;
    logic                irq;

    int                  mismatches;
    int                  others;
    int                  tb_errors;
    logic                drained;
    integer              seed;
    int                  waited;
    int                  pick;

    tb_clock_gen #(.PERIOD_NS(8)) u_clk (.clk(clk));

    uart_tx_top #(
        .NUM_CH     (NUM_CH),
        .FIFO_DEPTH (FIFO_DEPTH),
        .BAUD_DIV   (BAUD_DIV)
    ) UUT (
        .clk (clk), .rst_n (rst_n), .hsel (hsel), .haddr (haddr), .hwrite (hwrite),
        .hsize (hsize), .hburst (hburst), .htrans (htrans), .hmastlock (hmastlock),
        .hwdata (hwdata), .hrdata (hrdata), .hready (hready), .hresp (hresp),
        .int_clear (int_clear), .tx (tx), .irq (irq)
    );

    uart_tx_checker #(
        .NUM_CH     (NUM_CH),
        .FIFO_DEPTH (FIFO_DEPTH),
        .BAUD_DIV   (BAUD_DIV)
    ) u_chk (
        .clk (clk), .rst_n (rst_n), .hsel (hsel), .haddr (haddr), .hwrite (hwrite),
        .htrans (htrans), .hwdata (hwdata), .int_clear (int_clear), .hrdata (hrdata),
        .hresp (hresp), .tx (tx), .irq (irq), .mismatches (mismatches),
        .others (others), .drained (drained)
    );

    // one bus cycle, address phase of this transfer and data of the last one
    task automatic bus_cycle(input logic sel, input int ch, input int ofs,
                             input logic wr, input logic clr);
        @(negedge clk);
        hsel      = sel;
        haddr     = WORD_W'(ch * CH_STRIDE + ofs);
        hwrite    = wr;
        htrans    = sel ? HTRANS_NONSEQ : HTRANS_IDLE;
        hwdata    = $random(seed);
        int_clear = clr;
    endtask

    task automatic bus_idle();
        bus_cycle(1'b0, 0, 0, 1'b0, 1'b0);
    endtask

    task automatic random_cycle();
        int ch;
        pick = $unsigned($random(seed)) % 100;
        ch   = $unsigned($random(seed)) % NUM_CH;
        if (pick < 4)       bus_cycle(1'b1, ch, OFS_TXDATA, 1'b1, 1'b0);
        else if (pick < 7)  bus_cycle(1'b1, ch, OFS_STATUS, 1'b0, 1'b0);
        else if (pick == 7) bus_cycle(1'b1, ch, OFS_TXDATA, 1'b0, 1'b0);   // forbidden read
        else if (pick == 8) bus_cycle(1'b0, 0, 0, 1'b0, 1'b1);
        else if (pick == 9) bus_cycle(1'b1, ch, 8, 1'b0, 1'b0);            // unmapped offset
        else                bus_idle();
    endtask

    initial begin
        seed      = 32'h71cf_5b3e;
        tb_errors = 0;
        rst_n     = 1'b0;
        hsel      = 1'b0;
        haddr     = '0;
        hwrite    = 1'b0;
        hsize     = 3'b010;
        hburst    = 3'b000;
        htrans    = HTRANS_IDLE;
        hmastlock = 1'b0;
        hwdata    = '0;
        int_clear = 1'b0;
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        // quiet bus after reset
        repeat (30) bus_idle();

        repeat (1500) random_cycle();

        // overfill each fifo, status read in the middle
        for (int c = 0; c < NUM_CH; c++) begin
            repeat (FIFO_DEPTH + 2) bus_cycle(1'b1, c, OFS_TXDATA, 1'b1, 1'b0);
            bus_cycle(1'b1, c, OFS_STATUS, 1'b0, 1'b0);
            repeat (2) bus_cycle(1'b1, c, OFS_TXDATA, 1'b1, 1'b0);
        end

        repeat (2500) random_cycle();

        // let every line empty
        waited = 0;
        bus_idle();
        while (!drained && waited < DRAIN_LIMIT) begin
            bus_idle();
            waited++;
        end
        if (!drained) begin
            $display("ERROR: timed out waiting for the tx lines to drain");
            tb_errors++;
        end
        repeat (10) bus_idle();
        bus_cycle(1'b0, 0, 0, 1'b0, 1'b1);
        repeat (10) bus_idle();

        $display("checks done: %0d mismatches, %0d other errors", mismatches,
                 others + tb_errors);
        if (mismatches == 0 && others == 0 && tb_errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

// File: src.f
logic/uart_pkg.sv
logic/tx_word_fifo.sv
logic/uart_tx_channel.sv
logic/ahb_uart_regs.sv
logic/uart_irq_ctrl.sv
logic/uart_tx_top.sv
test/tb_clock_gen.sv
test/uart_tx_asserts.sv
test/uart_tx_checker.sv
test/uart_tx_tb.sv

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module uart_tx_tb \
    -f src.f -o uart_tx_sim > build.log 2>&1 \
    && ./obj_dir/uart_tx_sim > sim.log 2>&1 \
    || { echo "build or simulation did not complete"; exit 1; }
grep -q "Simulation finished: FAIL" sim.log && { echo "test failed"; exit 1; } \
    || grep -q "Simulation finished: PASS" sim.log \
    || { echo "no result line in sim.log"; exit 1; }
echo "test passed"
